// File: rtl/riscv_v_pkg.sv
// Shared widths, types and OP-V encodings for the vector unit.
// Every RTL module imports this package by wildcard in its header.
`default_nettype none

package riscv_v_pkg;

// Default vector register width in bits
parameter int VLEN = 64;
// Fixed element width
parameter int SEW = 8;

typedef logic [31:0]    riscv_data_t;
typedef logic [31:0]    riscv_instruction_t;
typedef logic [SEW-1:0] riscv_v_elem_t;
typedef logic [4:0]     riscv_instr_rs_t;
typedef logic [4:0]     riscv_instr_rd_t;

// CSR fields
typedef logic [7:0]     riscv_v_vl_t;
typedef logic [7:0]     riscv_v_vstart_t;
typedef logic [1:0]     riscv_v_vxrm_t;
typedef logic [7:0]     riscv_v_vlenb_t;

typedef enum logic [2:0] {
    OP_NONE,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_MERGE
} riscv_v_op_e;

// Where operand A comes from
typedef enum logic [1:0] {
    SRC_VV,
    SRC_VX,
    SRC_VI
} riscv_v_src_e;

localparam logic [6:0] OPCODE_OPV = 7'b1010111;

// funct3 operand categories
localparam logic [2:0] OPIVV = 3'b000;
localparam logic [2:0] OPIVI = 3'b011;
localparam logic [2:0] OPIVX = 3'b100;

// funct6 values
localparam logic [5:0] F6_VADD   = 6'b000000;
localparam logic [5:0] F6_VSUB   = 6'b000010;
localparam logic [5:0] F6_VAND   = 6'b001001;
localparam logic [5:0] F6_VOR    = 6'b001010;
localparam logic [5:0] F6_VXOR   = 6'b001011;
localparam logic [5:0] F6_VMERGE = 6'b010111;

endpackage

`default_nettype wire

// File: rtl/riscv_v_exe_if.sv
// Decode-to-ALU link. Decode drives operands, control and the CSR view,
// the ALU returns element results and per-element write enables.
`default_nettype none

interface riscv_v_exe_if import riscv_v_pkg::*; #(
    parameter int VLEN = riscv_v_pkg::VLEN
);

localparam int LANES = VLEN / SEW;

logic                valid_exe;
riscv_v_op_e         op_exe;
riscv_v_src_e        src_exe;
logic                use_mask_exe;
logic [VLEN-1:0]     srca_exe;
logic [VLEN-1:0]     srcb_exe;
riscv_data_t         scalar_exe;
riscv_v_elem_t       imm_exe;
logic [LANES-1:0]    mask_exe;
riscv_v_vl_t         vl;
riscv_v_vstart_t     vstart;
// Results back to decode
logic [VLEN-1:0]     result_data_exe;
logic [LANES-1:0]    result_wr_en_exe;

modport decode (
    output valid_exe, op_exe, src_exe, use_mask_exe, srca_exe, srcb_exe,
    output scalar_exe, imm_exe, mask_exe, vl, vstart,
    input  result_data_exe, result_wr_en_exe
);

modport alu (
    input  valid_exe, op_exe, src_exe, use_mask_exe, srca_exe, srcb_exe,
    input  scalar_exe, imm_exe, mask_exe, vl, vstart,
    output result_data_exe, result_wr_en_exe
);

endinterface

`default_nettype wire

// File: rtl/riscv_v_ctrl.sv
// OP-V instruction decoder and the ID-to-EXE control register.
// Hazards turn the EXE slot into a bubble, the host stall freezes it.
`default_nettype none

module riscv_v_ctrl import riscv_v_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  logic                riscv_stall,
    input  logic                hazard,
    input  riscv_instruction_t  instruction_id,
    output logic                stall,
    output riscv_instr_rs_t     vs1_id,
    output riscv_instr_rs_t     vs2_id,
    output riscv_instr_rs_t     vd_id,
    output logic                uses_vs1_id,
    output logic                needs_mask_id,
    riscv_v_exe_if.decode       exe
);

logic [6:0]      opcode_id;
logic [2:0]      funct3_id;
logic [5:0]      funct6_id;
logic            vm_id;
riscv_v_op_e     op_id;
riscv_v_src_e    src_id;
riscv_v_elem_t   imm_id;

assign opcode_id = instruction_id[6:0];
assign vd_id     = instruction_id[11:7];
assign funct3_id = instruction_id[14:12];
assign vs1_id    = instruction_id[19:15];
assign vs2_id    = instruction_id[24:20];
assign vm_id     = instruction_id[25];
assign funct6_id = instruction_id[31:26];

// simm5 shares the vs1 field
assign imm_id = {{(SEW-5){instruction_id[19]}}, instruction_id[19:15]};

always_comb begin
    op_id = OP_NONE;
    case (funct3_id)
        OPIVX:   src_id = SRC_VX;
        OPIVI:   src_id = SRC_VI;
        default: src_id = SRC_VV;
    endcase
    if (opcode_id == OPCODE_OPV &&
        (funct3_id == OPIVV || funct3_id == OPIVX || funct3_id == OPIVI)) begin
        case (funct6_id)
            F6_VADD:   op_id = OP_ADD;
            F6_VSUB:   op_id = OP_SUB;
            F6_VAND:   op_id = OP_AND;
            F6_VOR:    op_id = OP_OR;
            F6_VXOR:   op_id = OP_XOR;
            F6_VMERGE: op_id = OP_MERGE;
            default:   op_id = OP_NONE;
        endcase
    end
end

assign uses_vs1_id   = (op_id != OP_NONE) && (src_id == SRC_VV);
assign needs_mask_id = (op_id != OP_NONE) && !vm_id;
assign stall         = riscv_stall | hazard;

always_ff @(posedge clk) begin
    if (rst) begin
        exe.valid_exe <= 1'b0;
        exe.op_exe    <= OP_NONE;
    end else if (!riscv_stall) begin
        // Unknown words and hazards enter EXE as bubbles
        exe.valid_exe <= instr_valid && !hazard && (op_id != OP_NONE);
        exe.op_exe    <= op_id;
    end
end

always_ff @(posedge clk) begin
    if (!riscv_stall) begin
        exe.src_exe      <= src_id;
        exe.use_mask_exe <= !vm_id;
        exe.imm_exe      <= imm_id;
    end
end

// A stalled instruction stays on the port until it is accepted
a_hold_stalled: assert property (@(posedge clk) disable iff (rst)
    instr_valid && stall |=> instr_valid && $stable(instruction_id));

endmodule

`default_nettype wire

// File: rtl/riscv_v_csr.sv
// Vector CSRs vl, vstart and vxrm with an external write port.
// vlenb is a constant derived from the register width.
`default_nettype none

module riscv_v_csr import riscv_v_pkg::*; #(
    parameter int VLEN = riscv_v_pkg::VLEN
) (
    input  logic              clk,
    input  logic              rst,
    input  riscv_data_t       ext_data_in,
    input  logic              ext_wr_vl,
    input  logic              ext_wr_vstart,
    input  logic              ext_wr_vxrm,
    output riscv_v_vl_t       vl,
    output riscv_v_vstart_t   vstart,
    output riscv_v_vxrm_t     vxrm,
    output riscv_v_vlenb_t    vlenb
);

// Element count of one register at the fixed SEW
localparam riscv_v_vl_t VLMAX = riscv_v_vl_t'(VLEN / SEW);

riscv_v_vl_t   vl_wr;

// Truncate to the field first, then clamp to the lane count
assign vl_wr = riscv_v_vl_t'(ext_data_in);

always_ff @(posedge clk) begin
    if (rst) begin
        vl     <= '0;
        vstart <= '0;
        vxrm   <= '0;
    end else begin
        if (ext_wr_vl) begin
            vl <= (vl_wr > VLMAX) ? VLMAX : vl_wr;
        end
        if (ext_wr_vstart) begin
            vstart <= riscv_v_vstart_t'(ext_data_in);
        end
        if (ext_wr_vxrm) begin
            vxrm <= riscv_v_vxrm_t'(ext_data_in);
        end
    end
end

assign vlenb = riscv_v_vlenb_t'(VLEN / 8);

endmodule

`default_nettype wire

// File: rtl/riscv_v_rf.sv
// 32-entry vector register file. Reads are asynchronous, writes are
// element-granular. v0 is also read out as the per-element mask.
`default_nettype none

module riscv_v_rf import riscv_v_pkg::*; #(
    parameter int VLEN = riscv_v_pkg::VLEN
) (
    input  logic                   clk,
    input  riscv_instr_rs_t        rd_addr_a,
    input  riscv_instr_rs_t        rd_addr_b,
    input  riscv_instr_rs_t        wr_addr,
    input  riscv_instr_rs_t        syn_addr,
    input  logic [VLEN/SEW-1:0]    wr_en,
    input  logic [VLEN-1:0]        data_in,
    output logic [VLEN-1:0]        data_out_a,
    output logic [VLEN-1:0]        data_out_b,
    output logic [VLEN/SEW-1:0]    mask,
    output logic [VLEN-1:0]        syn_data
);

localparam int LANES = VLEN / SEW;
localparam int NREGS = 32;

logic [VLEN-1:0] regs [NREGS];

// Only enabled elements change
always_ff @(posedge clk) begin
    for (int i = 0; i < LANES; i++) begin
        if (wr_en[i]) begin
            regs[wr_addr][i*SEW +: SEW] <= data_in[i*SEW +: SEW];
        end
    end
end

assign data_out_a = regs[rd_addr_a];
assign data_out_b = regs[rd_addr_b];

// Mask bit i is bit i of v0
assign mask = regs[0][LANES-1:0];

// Debug port for inspection of architectural state
assign syn_data = regs[syn_addr];

endmodule

`default_nettype wire

// File: rtl/riscv_v_rf_ctrl.sv
// Operand registers into EXE, the EXE/MEM/WB write pipeline and RAW
// hazard detection against every in-flight destination.
`default_nettype none

module riscv_v_rf_ctrl import riscv_v_pkg::*; #(
    parameter int VLEN = riscv_v_pkg::VLEN
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   exe_valid,
    input  riscv_instr_rs_t        vs1_id,
    input  riscv_instr_rs_t        vs2_id,
    input  riscv_instr_rs_t        vd_id,
    input  logic                   uses_vs1_id,
    input  logic                   needs_mask_id,
    input  logic [VLEN-1:0]        rf_rd_data_srca_id,
    input  logic [VLEN-1:0]        rf_rd_data_srcb_id,
    input  logic [VLEN/SEW-1:0]    mask_id,
    input  riscv_data_t            int_rf_rd_data_id,
    riscv_v_exe_if.decode          exe,
    output riscv_instr_rd_t        rf_wr_addr_wb,
    output logic [VLEN/SEW-1:0]    rf_wr_en_wb,
    output logic [VLEN-1:0]        rf_wr_data_wb,
    output logic                   hazard
);

localparam int LANES = VLEN / SEW;

riscv_instr_rd_t    vd_exe;
riscv_instr_rd_t    vd_mem;
logic               valid_mem;
logic               valid_wb;
logic [LANES-1:0]   wr_en_mem;
logic [VLEN-1:0]    wr_data_mem;

always_ff @(posedge clk) begin
    if (rst) begin
        valid_mem   <= 1'b0;
        valid_wb    <= 1'b0;
        wr_en_mem   <= '0;
        rf_wr_en_wb <= '0;
    end else if (!stall) begin
        valid_mem   <= exe_valid;
        wr_en_mem   <= exe.result_wr_en_exe;
        valid_wb    <= valid_mem;
        rf_wr_en_wb <= wr_en_mem;
    end
end

always_ff @(posedge clk) begin
    if (!stall) begin
        exe.srca_exe   <= rf_rd_data_srca_id;
        exe.srcb_exe   <= rf_rd_data_srcb_id;
        exe.scalar_exe <= int_rf_rd_data_id;
        exe.mask_exe   <= mask_id;
        vd_exe         <= vd_id;
        vd_mem         <= vd_exe;
        rf_wr_addr_wb  <= vd_mem;
        wr_data_mem    <= exe.result_data_exe;
        rf_wr_data_wb  <= wr_data_mem;
    end
end

// True when a valid older instruction will still write addr
function automatic logic in_flight(input riscv_instr_rs_t addr);
    return (exe_valid && vd_exe == addr) ||
           (valid_mem && vd_mem == addr) ||
           (valid_wb && rf_wr_addr_wb == addr);
endfunction

always_comb begin
    hazard = (uses_vs1_id && in_flight(vs1_id)) ||
             in_flight(vs2_id) ||
             (needs_mask_id && in_flight(5'd0));
end

a_wb_en_valid: assert property (@(posedge clk) disable iff (rst)
    |rf_wr_en_wb |-> valid_wb);

endmodule

`default_nettype wire

// File: rtl/riscv_v_decode.sv
// Vector decode stage. Joins the instruction decoder, the CSRs, the
// operand and write pipeline and the register file, and presents the
// EXE operands to the ALU through the exe interface.
`default_nettype none

module riscv_v_decode import riscv_v_pkg::*; #(
    parameter int VLEN = riscv_v_pkg::VLEN
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  logic                riscv_stall,
    input  riscv_instruction_t  instruction_id,
    input  riscv_data_t         int_rf_rd_data_id,
    input  riscv_data_t         ext_data_in,
    input  logic                ext_wr_vl,
    input  logic                ext_wr_vstart,
    input  logic                ext_wr_vxrm,
    output logic                riscv_v_stall,
    output riscv_v_vl_t         vl,
    output riscv_v_vstart_t     vstart,
    output riscv_v_vxrm_t       vxrm,
    output riscv_v_vlenb_t      vlenb,
    input  riscv_instr_rs_t     syn_addr,
    output logic [VLEN-1:0]     syn_data,
    riscv_v_exe_if.decode       exe
);

localparam int LANES = VLEN / SEW;

logic               stall;
logic               hazard;
riscv_instr_rs_t    vs1_id;
riscv_instr_rs_t    vs2_id;
riscv_instr_rs_t    vd_id;
logic               uses_vs1_id;
logic               needs_mask_id;
logic [VLEN-1:0]    rf_rd_data_srca_id;
logic [VLEN-1:0]    rf_rd_data_srcb_id;
logic [LANES-1:0]   mask_id;
riscv_instr_rd_t    rf_wr_addr_wb;
logic [LANES-1:0]   rf_wr_en_wb;
logic [VLEN-1:0]    rf_wr_data_wb;

assign riscv_v_stall = stall;
assign exe.vl        = vl;
assign exe.vstart    = vstart;

riscv_v_ctrl v_ctrl (
    .clk(clk),
    .rst(rst),
    .instr_valid(instr_valid),
    .riscv_stall(riscv_stall),
    .hazard(hazard),
    .instruction_id(instruction_id),
    .stall(stall),
    .vs1_id(vs1_id),
    .vs2_id(vs2_id),
    .vd_id(vd_id),
    .uses_vs1_id(uses_vs1_id),
    .needs_mask_id(needs_mask_id),
    .exe(exe)
);

riscv_v_csr #(.VLEN(VLEN)) v_csr (
    .clk(clk),
    .rst(rst),
    .ext_data_in(ext_data_in),
    .ext_wr_vl(ext_wr_vl),
    .ext_wr_vstart(ext_wr_vstart),
    .ext_wr_vxrm(ext_wr_vxrm),
    .vl(vl),
    .vstart(vstart),
    .vxrm(vxrm),
    .vlenb(vlenb)
);

// Back stages hold only on the host stall, so an older write can retire
// while a hazard keeps the younger instruction in ID
riscv_v_rf_ctrl #(.VLEN(VLEN)) v_rf_ctrl (
    .clk(clk),
    .rst(rst),
    .stall(riscv_stall),
    .exe_valid(exe.valid_exe),
    .vs1_id(vs1_id),
    .vs2_id(vs2_id),
    .vd_id(vd_id),
    .uses_vs1_id(uses_vs1_id),
    .needs_mask_id(needs_mask_id),
    .rf_rd_data_srca_id(rf_rd_data_srca_id),
    .rf_rd_data_srcb_id(rf_rd_data_srcb_id),
    .mask_id(mask_id),
    .int_rf_rd_data_id(int_rf_rd_data_id),
    .exe(exe),
    .rf_wr_addr_wb(rf_wr_addr_wb),
    .rf_wr_en_wb(rf_wr_en_wb),
    .rf_wr_data_wb(rf_wr_data_wb),
    .hazard(hazard)
);

riscv_v_rf #(.VLEN(VLEN)) v_rf (
    .clk(clk),
    .rd_addr_a(vs1_id),
    .rd_addr_b(vs2_id),
    .wr_addr(rf_wr_addr_wb),
    .syn_addr(syn_addr),
    .wr_en(rf_wr_en_wb),
    .data_in(rf_wr_data_wb),
    .data_out_a(rf_rd_data_srca_id),
    .data_out_b(rf_rd_data_srcb_id),
    .mask(mask_id),
    .syn_data(syn_data)
);

endmodule

`default_nettype wire

// File: rtl/riscv_v_alu.sv
// Lane ALU in EXE. Each lane computes vs2 op A and decides whether its
// element is written, from the body limits and the v0 mask.
`default_nettype none

module riscv_v_alu import riscv_v_pkg::*; #(
    parameter int VLEN = riscv_v_pkg::VLEN
) (
    riscv_v_exe_if.alu exe
);

localparam int LANES = VLEN / SEW;

for (genvar i = 0; i < LANES; i++) begin : g_lane
    riscv_v_elem_t  opa;
    riscv_v_elem_t  opb;
    riscv_v_elem_t  res;
    logic           in_body;
    logic           active;

    assign opb = exe.srcb_exe[i*SEW +: SEW];

    // Operand A by instruction form
    always_comb begin
        case (exe.src_exe)
            SRC_VX:  opa = exe.scalar_exe[SEW-1:0];
            SRC_VI:  opa = exe.imm_exe;
            default: opa = exe.srca_exe[i*SEW +: SEW];
        endcase
    end

    always_comb begin
        case (exe.op_exe)
            OP_ADD:   res = opb + opa;
            OP_SUB:   res = opb - opa;
            OP_AND:   res = opb & opa;
            OP_OR:    res = opb | opa;
            OP_XOR:   res = opb ^ opa;
            // vm=1 is vmv, which takes A everywhere
            OP_MERGE: res = (exe.use_mask_exe && !exe.mask_exe[i]) ? opb : opa;
            default:  res = opb;
        endcase
    end

    assign in_body = (i >= int'(exe.vstart)) && (i < int'(exe.vl));

    // Merge writes the whole body, other ops skip masked-off elements
    assign active = !exe.use_mask_exe || exe.mask_exe[i] || (exe.op_exe == OP_MERGE);

    assign exe.result_data_exe[i*SEW +: SEW] = res;
    assign exe.result_wr_en_exe[i]          = exe.valid_exe && in_body && active;
end

endmodule

`default_nettype wire

// File: rtl/riscv_v_core.sv
// Top level of the vector unit. Decode and the lane ALU meet through
// the exe interface; the host sees plain ports only.
`default_nettype none

module riscv_v_core import riscv_v_pkg::*; #(
    parameter int VLEN = riscv_v_pkg::VLEN
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  logic                riscv_stall,
    input  riscv_instruction_t  instruction_id,
    input  riscv_data_t         int_rf_rd_data_id,
    input  riscv_data_t         ext_data_in,
    input  logic                ext_wr_vl,
    input  logic                ext_wr_vstart,
    input  logic                ext_wr_vxrm,
    output logic                riscv_v_stall,
    output riscv_v_vl_t         vl,
    output riscv_v_vstart_t     vstart,
    output riscv_v_vxrm_t       vxrm,
    output riscv_v_vlenb_t      vlenb,
    input  riscv_instr_rs_t     syn_addr,
    output logic [VLEN-1:0]     syn_data
);

riscv_v_exe_if #(.VLEN(VLEN)) exe_if ();

riscv_v_decode #(.VLEN(VLEN)) v_decode (
    .clk(clk),
    .rst(rst),
    .instr_valid(instr_valid),
    .riscv_stall(riscv_stall),
    .instruction_id(instruction_id),
    .int_rf_rd_data_id(int_rf_rd_data_id),
    .ext_data_in(ext_data_in),
    .ext_wr_vl(ext_wr_vl),
    .ext_wr_vstart(ext_wr_vstart),
    .ext_wr_vxrm(ext_wr_vxrm),
    .riscv_v_stall(riscv_v_stall),
    .vl(vl),
    .vstart(vstart),
    .vxrm(vxrm),
    .vlenb(vlenb),
    .syn_addr(syn_addr),
    .syn_data(syn_data),
    .exe(exe_if.decode)
);

riscv_v_alu #(.VLEN(VLEN)) v_alu (
    .exe(exe_if.alu)
);

endmodule

`default_nettype wire

// File: sim/riscv_v_core_tb.sv
// Random-stimulus testbench for the vector unit top level.
// An architectural model applies each instruction when it is accepted,
// and the register file is compared through the syn_addr debug port.
`default_nettype none

module riscv_v_core_tb import riscv_v_pkg::*; ();

localparam int CLK_PERIOD = 4;
localparam int LANES      = VLEN / SEW;
// Init phases, arithmetic, masking, merge, dependencies, back-pressure
localparam int N_INSTR    = 32 * LANES + 200 + 200 + 100 + 28 + 150;
localparam int TIMEOUT    = (20 * N_INSTR + 2000) * CLK_PERIOD;

logic                clk = 1'b0;
logic                rst;
logic                instr_valid;
logic                riscv_stall;
riscv_instruction_t  instruction_id;
riscv_data_t         int_rf_rd_data_id;
riscv_data_t         ext_data_in;
logic                ext_wr_vl;
logic                ext_wr_vstart;
logic                ext_wr_vxrm;
logic                riscv_v_stall;
riscv_v_vl_t         vl;
riscv_v_vstart_t     vstart;
riscv_v_vxrm_t       vxrm;
riscv_v_vlenb_t      vlenb;
riscv_instr_rs_t     syn_addr;
logic [VLEN-1:0]     syn_data;

logic [VLEN-1:0]     model_rf [32];
riscv_v_vl_t         m_vl;
riscv_v_vstart_t     m_vstart;
riscv_v_vxrm_t       m_vxrm;
logic [31:0]         lcg_state = 32'h0b6f_4353;
int                  errors = 0;
int                  stall_cycles = 0;

riscv_v_core #(.VLEN(VLEN)) riscv_v_core_inst (
    .clk(clk),
    .rst(rst),
    .instr_valid(instr_valid),
    .riscv_stall(riscv_stall),
    .instruction_id(instruction_id),
    .int_rf_rd_data_id(int_rf_rd_data_id),
    .ext_data_in(ext_data_in),
    .ext_wr_vl(ext_wr_vl),
    .ext_wr_vstart(ext_wr_vstart),
    .ext_wr_vxrm(ext_wr_vxrm),
    .riscv_v_stall(riscv_v_stall),
    .vl(vl),
    .vstart(vstart),
    .vxrm(vxrm),
    .vlenb(vlenb),
    .syn_addr(syn_addr),
    .syn_data(syn_data)
);

always #(CLK_PERIOD / 2) clk = ~clk;

function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic int rand_below(input int n);
    return int'(next_rand() >> 8) % n;
endfunction

function automatic riscv_instruction_t encode(input logic [5:0] f6, input logic vm,
        input riscv_instr_rs_t vs2, input riscv_instr_rs_t vs1, input logic [2:0] f3,
        input riscv_instr_rd_t vd);
    return {f6, vm, vs2, vs1, f3, vd, OPCODE_OPV};
endfunction

// Ops numbered add, sub, and, or, xor, merge
function automatic riscv_instruction_t random_instr(input int first_op, input int n_ops,
        input logic masked);
    logic [5:0] f6;
    logic [2:0] f3;
    logic       vm;
    case (first_op + rand_below(n_ops))
        0:       f6 = F6_VADD;
        1:       f6 = F6_VSUB;
        2:       f6 = F6_VAND;
        3:       f6 = F6_VOR;
        4:       f6 = F6_VXOR;
        default: f6 = F6_VMERGE;
    endcase
    case (rand_below(3))
        0:       f3 = OPIVV;
        1:       f3 = OPIVX;
        default: f3 = OPIVI;
    endcase
    vm = masked ? (rand_below(2) == 1) : 1'b1;
    return encode(f6, vm, 5'(rand_below(32)), 5'(rand_below(32)), f3, 5'(rand_below(32)));
endfunction

// Architectural effect of one accepted instruction
task automatic apply_model(input riscv_instruction_t instr, input riscv_data_t scalar);
    logic [5:0]      f6;
    logic [2:0]      f3;
    logic            vm;
    riscv_instr_rs_t vs1;
    riscv_instr_rs_t vs2;
    riscv_instr_rd_t vd;
    logic [7:0]      a;
    logic [7:0]      b;
    logic [7:0]      r;
    logic            on;
    logic [VLEN-1:0] next;
    f6  = instr[31:26];
    vm  = instr[25];
    vs2 = instr[24:20];
    vs1 = instr[19:15];
    f3  = instr[14:12];
    vd  = instr[11:7];
    if (instr[6:0] != OPCODE_OPV || !(f3 == OPIVV || f3 == OPIVX || f3 == OPIVI))
        return;
    if (!(f6 inside {F6_VADD, F6_VSUB, F6_VAND, F6_VOR, F6_VXOR, F6_VMERGE}))
        return;
    next = model_rf[vd];
    for (int i = 0; i < LANES; i++) begin
        b = model_rf[vs2][i*8 +: 8];
        case (f3)
            OPIVX:   a = scalar[7:0];
            OPIVI:   a = {{3{vs1[4]}}, vs1};
            default: a = model_rf[vs1][i*8 +: 8];
        endcase
        on = vm || model_rf[0][i];
        case (f6)
            F6_VADD: r = b + a;
            F6_VSUB: r = b - a;
            F6_VAND: r = b & a;
            F6_VOR:  r = b | a;
            F6_VXOR: r = b ^ a;
            default: r = on ? a : b;
        endcase
        if (i >= int'(m_vstart) && i < int'(m_vl) && (on || f6 == F6_VMERGE))
            next[i*8 +: 8] = r;
    end
    model_rf[vd] = next;
endtask

// Called right after a rising edge; returns on the edge that accepts
task automatic send(input riscv_instruction_t instr, input riscv_data_t scalar,
        input logic back_pressure);
    logic accepted;
    accepted = 1'b0;
    instr_valid       <= 1'b1;
    instruction_id    <= instr;
    int_rf_rd_data_id <= scalar;
    riscv_stall       <= back_pressure && (rand_below(4) == 0);
    while (!accepted) begin
        @(negedge clk);
        accepted = !riscv_v_stall;
        if (riscv_v_stall && !riscv_stall)
            stall_cycles++;
        @(posedge clk);
        if (!accepted)
            riscv_stall <= back_pressure && (rand_below(4) == 0);
    end
    apply_model(instr, scalar);
endtask

task automatic drain();
    int quiet;
    quiet = 0;
    instr_valid    <= 1'b0;
    riscv_stall    <= 1'b0;
    instruction_id <= '0;
    while (quiet < 4) begin
        @(negedge clk);
        quiet = riscv_v_stall ? 0 : quiet + 1;
        @(posedge clk);
    end
endtask

// which: 0 vl, 1 vstart, 2 vxrm
task automatic write_csr(input int which, input riscv_data_t value);
    ext_data_in   <= value;
    ext_wr_vl     <= (which == 0);
    ext_wr_vstart <= (which == 1);
    ext_wr_vxrm   <= (which == 2);
    @(posedge clk);
    ext_wr_vl     <= 1'b0;
    ext_wr_vstart <= 1'b0;
    ext_wr_vxrm   <= 1'b0;
    case (which)
        0:       m_vl = (value[7:0] > 8'(LANES)) ? 8'(LANES) : value[7:0];
        1:       m_vstart = value[7:0];
        default: m_vxrm = value[1:0];
    endcase
endtask

task automatic set_body(input int first, input int count);
    write_csr(1, riscv_data_t'(first));
    write_csr(0, riscv_data_t'(count));
endtask

task automatic check_csr();
    @(negedge clk);
    assert (vl == m_vl) else begin
        errors++;
        $display("Mismatch vl: got %h expected %h", vl, m_vl);
    end
    assert (vstart == m_vstart) else begin
        errors++;
        $display("Mismatch vstart: got %h expected %h", vstart, m_vstart);
    end
    assert (vxrm == m_vxrm) else begin
        errors++;
        $display("Mismatch vxrm: got %h expected %h", vxrm, m_vxrm);
    end
    assert (vlenb == 8'(VLEN / 8)) else begin
        errors++;
        $display("Mismatch vlenb: got %h expected %h", vlenb, 8'(VLEN / 8));
    end
    @(posedge clk);
endtask

task automatic check_rf();
    for (int r = 0; r < 32; r++) begin
        syn_addr <= 5'(r);
        @(negedge clk);
        assert (syn_data == model_rf[r]) else begin
            errors++;
            $display("Mismatch syn_data v%0d: got %h expected %h", r, syn_data, model_rf[r]);
        end
        @(posedge clk);
    end
endtask

initial begin
    rst               <= 1'b1;
    instr_valid       <= 1'b0;
    riscv_stall       <= 1'b0;
    instruction_id    <= '0;
    int_rf_rd_data_id <= '0;
    ext_data_in       <= '0;
    ext_wr_vl         <= 1'b0;
    ext_wr_vstart     <= 1'b0;
    ext_wr_vxrm       <= 1'b0;
    syn_addr          <= '0;
    m_vl     = '0;
    m_vstart = '0;
    m_vxrm   = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (!riscv_v_stall) else begin
        errors++;
        $display("riscv_v_stall is high right after reset");
    end
    check_csr();

    // CSR writes, large values exercise the vl clamp
    repeat (40) begin
        write_csr(rand_below(3),
                  (rand_below(2) == 0) ? next_rand() : riscv_data_t'(rand_below(12)));
        check_csr();
    end

    // Fill every register one element at a time with vmv.v.x
    for (int lane = 0; lane < LANES; lane++) begin
        set_body(lane, lane + 1);
        for (int r = 0; r < 32; r++)
            send(encode(F6_VMERGE, 1'b1, 5'd0, 5'd0, OPIVX, 5'(r)), next_rand(), 1'b0);
        drain();
    end
    check_rf();

    set_body(0, LANES);
    repeat (200) send(random_instr(0, 5, 1'b0), next_rand(), 1'b0);
    drain();
    check_rf();

    repeat (4) begin
        set_body(rand_below(LANES), rand_below(LANES + 4));
        repeat (50) send(random_instr(0, 5, 1'b1), next_rand(), 1'b0);
        drain();
    end
    check_rf();

    set_body(rand_below(3), LANES - rand_below(3));
    repeat (100) send(random_instr(5, 1, 1'b1), next_rand(), 1'b0);
    drain();
    check_rf();

    // Each instruction reads the previous destination
    set_body(0, LANES);
    stall_cycles = 0;
    for (int k = 0; k < 20; k++)
        send(encode(F6_VADD, 1'b1, 5'(1 + (k + 29) % 30), 5'(rand_below(32)), OPIVX,
                    5'(1 + k % 30)), next_rand(), 1'b0);
    drain();
    assert (stall_cycles > 0) else begin
        errors++;
        $display("Dependent chain was accepted without raising riscv_v_stall");
    end
    stall_cycles = 0;
    for (int k = 0; k < 8; k++)
        send(random_instr(0, 5, 1'b0) & 32'hfe00_707f |
             {7'd0, 5'(1 + rand_below(7)), 5'(1 + rand_below(7)), 3'd0, 5'(16 + k), 7'd0},
             next_rand(), 1'b0);
    drain();
    assert (stall_cycles == 0) else begin
        errors++;
        $display("Independent run stalled for %0d cycles", stall_cycles);
    end
    check_rf();

    // Host stall pulses with some non-vector words mixed in
    repeat (150) begin
        if (rand_below(10) == 0)
            send({25'(next_rand() >> 7), 7'b0110011}, next_rand(), 1'b1);
        else
            send(random_instr(0, 6, 1'b1), next_rand(), 1'b1);
    end
    drain();
    check_rf();

    $display("Errors: %0d", errors);
    if (errors == 0)
        $display("Test OK");
    else
        $display("Test FAILED");
    $finish;
end

initial begin
    #(TIMEOUT);
    $display("Watchdog expired before the tests completed");
    $display("Test FAILED");
    $finish;
end

endmodule

`default_nettype wire

// File: vlog.f
rtl/riscv_v_pkg.sv
rtl/riscv_v_exe_if.sv
rtl/riscv_v_ctrl.sv
rtl/riscv_v_csr.sv
rtl/riscv_v_rf.sv
rtl/riscv_v_rf_ctrl.sv
rtl/riscv_v_decode.sv
rtl/riscv_v_alu.sv
rtl/riscv_v_core.sv
sim/riscv_v_core_tb.sv

// File: Makefile
SIM := obj_dir/Vriscv_v_core_tb

.PHONY: all run clean

all: run

$(SIM): vlog.f $(wildcard rtl/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert -f vlog.f --top-module riscv_v_core_tb \
		-Mdir obj_dir -o Vriscv_v_core_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
